/* files.f */
+incdir+hw
hw/camera_pkg.sv
hw/crop.sv
hw/metering.sv
hw/capture_writer.sv
hw/camera_registers.sv
hw/buffer_arbiter.sv
hw/image_buffer.sv
hw/camera.sv
testbench/camera_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the camera testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps -f files.f \
    --top-module camera_tb -o camera_tb_sim \
    && ./obj_dir/camera_tb_sim | tee sim.log \
    && grep -q "^No errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/camera_tb.sv */
////////////////////////////////////////////////////////////
// Testbench for the camera receive top. Frames are 24 x 20
// with random pixels from a fixed seed. A model crops the
// same window and predicts metering and image bytes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "camera_settings.svh"

module camera_tb import camera_pkg::*; ();

localparam int FRAME_COLS = 24;
localparam int FRAME_ROWS = 20;
localparam int LINE_GAP = 4;
localparam int FRAME_GAP = 12;
localparam int WINDOW_PIXELS =
    (`CROP_X_END - `CROP_X_START + 1) * (`CROP_Y_END - `CROP_Y_START + 1);
localparam int RESPONSE_TIMEOUT = 64;
localparam int RANDOM_READS = 48;

logic mipi_byte_clock;
logic mipi_byte_reset_n;
pixel_t pixel_data_i;
logic line_valid_i;
logic frame_valid_i;
byte_t op_code_i;
logic op_code_valid_i;
byte_t operand_i;
logic operand_valid_i;
byte_t response_o;
logic response_valid_o;

int seed;
int cycle_count;
int issue_cycle; // Cycle in which the last op code was driven
int error_count;
int check_count;
int tests_run;
int test_errors_start;
string test_name;
byte_t image_model [WINDOW_PIXELS];
byte_t prev_image [WINDOW_PIXELS];
int pixel_cycle [WINDOW_PIXELS]; // Cycle each window pixel was driven
byte_t expected_meter;

camera uut (.*);

always #4 mipi_byte_clock = ~mipi_byte_clock;

always @(posedge mipi_byte_clock) cycle_count <= cycle_count + 1;

task automatic check_byte(input byte_t expected, input byte_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("error %s: expected %h, actual %h", test_name, expected, actual);
    end
endtask

task automatic check_size(input byte_addr_t expected, input byte_addr_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("error %s: expected %0d, actual %0d", test_name, expected, actual);
    end
endtask

task automatic start_test(input string name);
    test_name = name;
    test_errors_start = error_count;
endtask

task automatic end_test();
    tests_run++;
    if (error_count == test_errors_start) $display("test %s passed", test_name);
    else $display("test %s failed with %0d errors", test_name, error_count - test_errors_start);
endtask

task automatic pulse_op(input byte_t op);
    @(posedge mipi_byte_clock);
    #1;
    op_code_i = op;
    op_code_valid_i = 1'b1;
    issue_cycle = cycle_count;
    @(posedge mipi_byte_clock);
    #1;
    op_code_valid_i = 1'b0;
endtask

task automatic set_address(input byte_addr_t address);
    pulse_op(8'h20);
    operand_i = address[15:8]; // High byte first
    operand_valid_i = 1'b1;
    @(posedge mipi_byte_clock);
    #1;
    operand_i = address[7:0];
    @(posedge mipi_byte_clock);
    #1;
    operand_valid_i = 1'b0;
endtask

task automatic query(input byte_t op, output byte_t data);
    int waited;
    waited = 0;
    data = '0;
    pulse_op(op);
    @(negedge mipi_byte_clock);
    while (!response_valid_o && waited < RESPONSE_TIMEOUT) begin
        @(negedge mipi_byte_clock);
        waited++;
    end
    if (response_valid_o) begin
        data = response_o;
    end else begin
        error_count++;
        $display("timeout: no response to op code %h in test %s", op, test_name);
    end
endtask

task automatic verify_status(input byte_t expected);
    byte_t data;
    query(8'h11, data);
    check_byte(expected, data);
endtask

task automatic compare_image_size(input byte_addr_t expected);
    byte_t low;
    byte_t high;
    query(8'h12, low);
    query(8'h13, high);
    check_size(expected, {high, low});
endtask

task automatic metering_matches();
    byte_t data;
    query(8'h30, data);
    check_byte(expected_meter, data);
endtask

task automatic read_back_image();
    byte_t data;
    set_address('0);
    for (int k = 0; k < WINDOW_PIXELS; k++) begin
        query(8'h22, data); // Address advances after each read
        check_byte(image_model[k], data);
    end
endtask

task automatic send_frame(input pixel_t mask);
    int sum;
    int k;
    pixel_t pixel;
    sum = 0;
    k = 0;
    for (int i = 0; i < WINDOW_PIXELS; i++) pixel_cycle[i] = 32'h7fffffff;
    @(posedge mipi_byte_clock);
    #1;
    frame_valid_i = 1'b1;
    @(posedge mipi_byte_clock);
    #1;
    for (int row = 0; row < FRAME_ROWS; row++) begin
        for (int col = 0; col < FRAME_COLS; col++) begin
            pixel = pixel_t'($random(seed)) & mask;
            pixel_data_i = pixel;
            line_valid_i = 1'b1;
            if (row >= `CROP_Y_START && row <= `CROP_Y_END &&
                col >= `CROP_X_START && col <= `CROP_X_END) begin
                image_model[k] = pixel[9:2];
                pixel_cycle[k] = cycle_count;
                sum += pixel[9:2];
                k++;
            end
            @(posedge mipi_byte_clock);
            #1;
        end
        line_valid_i = 1'b0;
        repeat (LINE_GAP) @(posedge mipi_byte_clock);
        #1;
    end
    frame_valid_i = 1'b0;
    expected_meter = byte_t'(sum >> `METER_SHIFT);
    repeat (FRAME_GAP) @(posedge mipi_byte_clock);
    #1;
endtask

// A word is in the buffer for a read issued after its last pixel was driven
task automatic random_reads();
    byte_addr_t address;
    byte_t data;
    byte_t expected;
    repeat (RANDOM_READS) begin
        address = byte_addr_t'($random(seed) & (WINDOW_PIXELS - 1));
        set_address(address);
        query(8'h22, data);
        if (pixel_cycle[address | 3] < issue_cycle) expected = image_model[address];
        else expected = prev_image[address];
        check_byte(expected, data);
    end
endtask

initial begin
    mipi_byte_clock = 1'b0;
    mipi_byte_reset_n = 1'b0;
    pixel_data_i = '0;
    line_valid_i = 1'b0;
    frame_valid_i = 1'b0;
    op_code_i = '0;
    op_code_valid_i = 1'b0;
    operand_i = '0;
    operand_valid_i = 1'b0;
    seed = 11;
    cycle_count = 0;
    issue_cycle = 0;
    error_count = 0;
    check_count = 0;
    tests_run = 0;
    repeat (5) @(posedge mipi_byte_clock);
    #1;
    mipi_byte_reset_n = 1'b1;

    start_test("reset");
    repeat (20) begin
        @(negedge mipi_byte_clock);
        if (response_valid_o) begin
            error_count++;
            $display("response_valid_o went high with no command in test %s", test_name);
        end
    end
    verify_status(8'h00);
    end_test();

    start_test("metering");
    send_frame(10'h3ff);
    metering_matches();
    end_test();

    start_test("capture");
    pulse_op(8'h10);
    send_frame(10'h3ff);
    verify_status(8'h01);
    compare_image_size(byte_addr_t'(WINDOW_PIXELS));
    end_test();

    start_test("readback");
    read_back_image();
    end_test();

    start_test("arbitration");
    prev_image = image_model;
    pulse_op(8'h10);
    fork
        send_frame(10'h3ff);
        random_reads();
    join
    verify_status(8'h01);
    end_test();

    start_test("recapture");
    pulse_op(8'h10);
    verify_status(8'h00);
    compare_image_size('0);
    send_frame(10'h1ff); // Darker frame so metering changes
    metering_matches();
    verify_status(8'h01);
    read_back_image();
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
    if (error_count == 0) begin
        $display("No errors");
    end else begin
        $display("Errors found");
    end
    $finish;
end

endmodule

/* hw/camera.sv */
////////////////////////////////////////////////////////////
// Camera receive top. Single clock domain; the pixel
// stream comes from a byte to pixel converter upstream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module camera import camera_pkg::*; (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input pixel_t pixel_data_i,
    input logic line_valid_i,
    input logic frame_valid_i,
    input byte_t op_code_i,
    input logic op_code_valid_i,
    input byte_t operand_i,
    input logic operand_valid_i,
    output byte_t response_o,
    output logic response_valid_o
);

pixel_t cropped_data;
logic cropped_line_valid, cropped_frame_valid;
byte_t metering_value;
logic metering_ready, start_capture;
logic write_request, image_ready, read_request, read_valid;
word_addr_t write_address, ram_address;
word_t write_data, ram_write_data, ram_read_data;
byte_addr_t image_size, read_address;
byte_t read_data;
logic ram_write_enable;

crop crop (
    .mipi_byte_clock, .mipi_byte_reset_n, .pixel_data_i, .line_valid_i, .frame_valid_i,
    .cropped_data_o(cropped_data), .line_valid_o(cropped_line_valid),
    .frame_valid_o(cropped_frame_valid)
);

metering metering (
    .mipi_byte_clock, .mipi_byte_reset_n, .data_i(cropped_data),
    .line_valid_i(cropped_line_valid), .frame_valid_i(cropped_frame_valid),
    .metering_o(metering_value), .metering_ready_o(metering_ready)
);

capture_writer capture_writer (
    .mipi_byte_clock, .mipi_byte_reset_n, .data_i(cropped_data),
    .line_valid_i(cropped_line_valid), .frame_valid_i(cropped_frame_valid),
    .start_capture_i(start_capture), .write_request_o(write_request),
    .write_address_o(write_address), .write_data_o(write_data),
    .image_ready_o(image_ready), .image_size_o(image_size)
);

camera_registers camera_registers (
    .mipi_byte_clock, .mipi_byte_reset_n, .op_code_i, .op_code_valid_i, .operand_i,
    .operand_valid_i, .response_o, .response_valid_o, .start_capture_o(start_capture),
    .image_ready_i(image_ready), .image_size_i(image_size), .metering_i(metering_value),
    .metering_ready_i(metering_ready), .read_request_o(read_request),
    .read_address_o(read_address), .read_data_i(read_data), .read_valid_i(read_valid)
);

buffer_arbiter buffer_arbiter (
    .mipi_byte_clock, .mipi_byte_reset_n, .write_request_i(write_request),
    .write_address_i(write_address), .write_data_i(write_data),
    .read_request_i(read_request), .read_address_i(read_address),
    .read_data_o(read_data), .read_valid_o(read_valid),
    .ram_write_enable_o(ram_write_enable), .ram_address_o(ram_address),
    .ram_write_data_o(ram_write_data), .ram_read_data_i(ram_read_data)
);

image_buffer image_buffer (
    .mipi_byte_clock, .write_enable_i(ram_write_enable), .address_i(ram_address),
    .write_data_i(ram_write_data), .read_data_o(ram_read_data)
);

endmodule

/* hw/image_buffer.sv */
////////////////////////////////////////////////////////////
// Single port word RAM, registered read.
// A read of the word being written returns the old value
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "camera_settings.svh"

module image_buffer import camera_pkg::*; (
    input logic mipi_byte_clock,
    input logic write_enable_i,
    input word_addr_t address_i,
    input word_t write_data_i,
    output word_t read_data_o
);

word_t memory [`BUFFER_WORDS];

always_ff @(posedge mipi_byte_clock) begin
    if (write_enable_i) begin
        memory[address_i] <= write_data_i;
    end
    read_data_o <= memory[address_i];
end

endmodule

/* hw/buffer_arbiter.sv */
////////////////////////////////////////////////////////////
// Shares the image buffer between writer and reader.
// Writes always win; a read waits for the next free cycle.
// The reader must drop its request after read_valid_o
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module buffer_arbiter import camera_pkg::*; (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input logic write_request_i,
    input word_addr_t write_address_i,
    input word_t write_data_i,
    input logic read_request_i,
    input byte_addr_t read_address_i,
    output byte_t read_data_o,
    output logic read_valid_o,
    output logic ram_write_enable_o,
    output word_addr_t ram_address_o,
    output word_t ram_write_data_o,
    input word_t ram_read_data_i
);

logic read_pending;  // Granted and not yet answered
logic read_granted;  // RAM data arrives this cycle
logic read_grant;
logic [1:0] read_lane;

assign read_grant = read_request_i && !read_pending && !write_request_i;

assign ram_write_enable_o = write_request_i;
assign ram_write_data_o = write_data_i;
assign ram_address_o = write_request_i ? write_address_i : word_addr_t'(read_address_i >> 2);

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        read_pending <= 1'b0;
        read_granted <= 1'b0;
        read_valid_o <= 1'b0;
    end else begin
        read_granted <= read_grant;
        read_valid_o <= read_granted;
        if (read_grant) read_pending <= 1'b1;
        else if (read_valid_o) read_pending <= 1'b0;
    end
end

always_ff @(posedge mipi_byte_clock) begin
    if (read_grant) read_lane <= read_address_i[1:0];
    if (read_granted) read_data_o <= ram_read_data_i[read_lane*8 +: 8];
end

endmodule

/* hw/camera_registers.sv */
////////////////////////////////////////////////////////////
// Byte command decoder. Only one command runs at a time;
// op codes arriving while busy are dropped
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module camera_registers import camera_pkg::*; (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input byte_t op_code_i,
    input logic op_code_valid_i,
    input byte_t operand_i,
    input logic operand_valid_i,
    output byte_t response_o,
    output logic response_valid_o,
    output logic start_capture_o,
    input logic image_ready_i,
    input byte_addr_t image_size_i,
    input byte_t metering_i,
    input logic metering_ready_i,
    output logic read_request_o,
    output byte_addr_t read_address_o,
    input byte_t read_data_i,
    input logic read_valid_i
);

localparam byte_t OP_START_CAPTURE = 8'h10;
localparam byte_t OP_STATUS = 8'h11;
localparam byte_t OP_SIZE_LO = 8'h12;
localparam byte_t OP_SIZE_HI = 8'h13;
localparam byte_t OP_SET_ADDRESS = 8'h20;
localparam byte_t OP_READ_BYTE = 8'h22;
localparam byte_t OP_METERING = 8'h30;

reg_state_t state;
byte_t metering_latch;

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        state <= REG_IDLE;
        response_o <= '0;
        response_valid_o <= 1'b0;
        start_capture_o <= 1'b0;
        read_request_o <= 1'b0;
        read_address_o <= '0;
        metering_latch <= '0;
    end else begin
        response_valid_o <= 1'b0;
        start_capture_o <= 1'b0;
        if (metering_ready_i) metering_latch <= metering_i;

        case (state)
            REG_IDLE: if (op_code_valid_i) begin
                case (op_code_i)
                    OP_START_CAPTURE: start_capture_o <= 1'b1;
                    OP_STATUS: begin
                        response_o <= {7'd0, image_ready_i};
                        response_valid_o <= 1'b1;
                    end
                    OP_SIZE_LO: begin
                        response_o <= image_size_i[7:0];
                        response_valid_o <= 1'b1;
                    end
                    OP_SIZE_HI: begin
                        response_o <= image_size_i[15:8];
                        response_valid_o <= 1'b1;
                    end
                    OP_SET_ADDRESS: state <= REG_ADDR_HI;
                    OP_READ_BYTE: begin
                        read_request_o <= 1'b1; // Held until the arbiter answers
                        state <= REG_READ_WAIT;
                    end
                    OP_METERING: begin
                        response_o <= metering_latch;
                        response_valid_o <= 1'b1;
                    end
                    default: ;
                endcase
            end
            REG_ADDR_HI: if (operand_valid_i) begin
                read_address_o[15:8] <= operand_i;
                state <= REG_ADDR_LO;
            end
            REG_ADDR_LO: if (operand_valid_i) begin
                read_address_o[7:0] <= operand_i;
                state <= REG_IDLE;
            end
            REG_READ_WAIT: if (read_valid_i) begin
                read_request_o <= 1'b0;
                response_o <= read_data_i;
                response_valid_o <= 1'b1;
                read_address_o <= read_address_o + 1'b1; // Auto increment
                state <= REG_IDLE;
            end
            default: state <= REG_IDLE;
        endcase
    end
end

endmodule

/* hw/capture_writer.sv */
////////////////////////////////////////////////////////////
// Captures one whole frame after each start command.
// A trailing partial word is dropped and not counted.
// Addresses wrap past the buffer depth
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module capture_writer import camera_pkg::*; (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input pixel_t data_i,
    input logic line_valid_i,
    input logic frame_valid_i,
    input logic start_capture_i,
    output logic write_request_o,
    output word_addr_t write_address_o,
    output word_t write_data_o,
    output logic image_ready_o,
    output byte_addr_t image_size_o
);

capture_state_t state;
byte_addr_t byte_count;
logic [23:0] pack_word; // Pixels 0 to 2 of the current word
logic frame_valid_prev;
logic frame_start;
logic capturing;
byte_t pixel_byte;

assign pixel_byte = data_i[9:2];
assign frame_start = frame_valid_i && !frame_valid_prev;
assign capturing = line_valid_i &&
    (state == CAP_CAPTURING || (state == CAP_ARMED && frame_start));

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        state <= CAP_IDLE;
        byte_count <= '0;
        frame_valid_prev <= 1'b0;
        write_request_o <= 1'b0;
        image_ready_o <= 1'b0;
        image_size_o <= '0;
    end else begin
        frame_valid_prev <= frame_valid_i;
        write_request_o <= capturing && (byte_count[1:0] == 2'd3);
        if (start_capture_i) begin
            state <= CAP_ARMED;
            byte_count <= '0;
            image_ready_o <= 1'b0;
            image_size_o <= '0;
        end else begin
            case (state)
                CAP_ARMED: if (frame_start) state <= CAP_CAPTURING;
                CAP_CAPTURING: if (frame_valid_prev && !frame_valid_i) begin
                    state <= CAP_DONE;
                    image_ready_o <= 1'b1;
                    image_size_o <= {byte_count[15:2], 2'b00}; // Whole words only
                end
                default: ;
            endcase
            if (capturing) byte_count <= byte_count + 1'b1;
        end
    end
end

always_ff @(posedge mipi_byte_clock) begin
    if (capturing) begin
        if (byte_count[1:0] == 2'd3) begin
            write_data_o <= {pixel_byte, pack_word};
            write_address_o <= word_addr_t'(byte_count >> 2);
        end else begin
            pack_word[byte_count[1:0]*8 +: 8] <= pixel_byte;
        end
    end
end

endmodule

/* hw/metering.sv */
////////////////////////////////////////////////////////////
// Average brightness of the upper 8 bits per frame.
// The sum is sized for a window of 2**METER_SHIFT pixels
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "camera_settings.svh"

module metering import camera_pkg::*; (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input pixel_t data_i,
    input logic line_valid_i,
    input logic frame_valid_i,
    output byte_t metering_o,
    output logic metering_ready_o
);

localparam int SUM_WIDTH = 8 + `METER_SHIFT;

logic [SUM_WIDTH-1:0] sum;
logic frame_valid_prev;
logic frame_end;
byte_t pixel_byte;

assign pixel_byte = data_i[9:2];
assign frame_end = frame_valid_prev && !frame_valid_i;

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        sum <= '0;
        frame_valid_prev <= 1'b0;
        metering_ready_o <= 1'b0;
        metering_o <= '0;
    end else begin
        frame_valid_prev <= frame_valid_i;
        metering_ready_o <= frame_end;
        if (frame_end) metering_o <= byte_t'(sum >> `METER_SHIFT);

        if (!frame_valid_i) sum <= '0; // Restart between frames
        else if (line_valid_i) sum <= sum + SUM_WIDTH'(pixel_byte);
    end
end

endmodule

/* hw/crop.sv */
////////////////////////////////////////////////////////////
// Fixed window crop. Output lags input by one cycle.
// Rows are counted on falling line valid
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "camera_settings.svh"

module crop import camera_pkg::*; (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input pixel_t pixel_data_i,
    input logic line_valid_i,
    input logic frame_valid_i,
    output pixel_t cropped_data_o,
    output logic line_valid_o,
    output logic frame_valid_o
);

coord_t x_count;
coord_t y_count;
logic line_valid_prev;
logic row_in_window;
logic column_in_window;

assign row_in_window = (y_count >= (`CROP_Y_START)) && (y_count <= (`CROP_Y_END));
assign column_in_window = (x_count >= (`CROP_X_START)) && (x_count <= (`CROP_X_END));

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        x_count <= '0;
        y_count <= '0;
        line_valid_prev <= 1'b0;
        line_valid_o <= 1'b0;
        frame_valid_o <= 1'b0;
    end else begin
        line_valid_prev <= line_valid_i;
        x_count <= line_valid_i ? x_count + 1'b1 : '0;
        if (!frame_valid_i) y_count <= '0;
        else if (line_valid_prev && !line_valid_i) y_count <= y_count + 1'b1; // End of row

        line_valid_o <= line_valid_i && row_in_window && column_in_window;
        frame_valid_o <= frame_valid_i && row_in_window;
    end
end

always_ff @(posedge mipi_byte_clock) begin
    cropped_data_o <= pixel_data_i;
end

endmodule

/* hw/camera_pkg.sv */
////////////////////////////////////////////////////////////
// Types shared by the camera receive path
////////////////////////////////////////////////////////////

package camera_pkg;

    typedef logic [9:0] pixel_t;      // Raw Bayer sample
    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;      // Four stored pixels
    typedef logic [5:0] word_addr_t;
    typedef logic [15:0] byte_addr_t;
    typedef logic [10:0] coord_t;

    typedef enum logic [1:0] {
        REG_IDLE, REG_ADDR_HI, REG_ADDR_LO, REG_READ_WAIT
    } reg_state_t;

    typedef enum logic [1:0] {
        CAP_IDLE, CAP_ARMED, CAP_CAPTURING, CAP_DONE
    } capture_state_t;

endpackage

/* hw/camera_settings.svh */
////////////////////////////////////////////////////////////
// Fixed crop window and image buffer depth.
// The window corners are inclusive; a 16 x 16 window is
// 256 pixels, which is what METER_SHIFT and BUFFER_WORDS expect
////////////////////////////////////////////////////////////

`ifndef CAMERA_SETTINGS_SVH
`define CAMERA_SETTINGS_SVH

`define CROP_X_START 4
`define CROP_X_END 19
`define CROP_Y_START 2
`define CROP_Y_END 17

`define METER_SHIFT 8 // log2 of window pixel count

`define BUFFER_WORDS 64

`endif
